//--- common/qspi_flash_pkg.sv
// opcodes, FSM states, lane modes, request structs and protocol constants of the flash model
`default_nettype none

package qspi_flash_pkg;

    localparam int ADDR_BITS  = 24;
    localparam int ADDR_BYTES = 3;    // address bytes after the opcode
    localparam int PAGE_BYTES = 256;  // program wraps inside one page
    localparam int FAST_DUMMY = 8;    // dummy edges for 0B
    localparam int DUAL_DUMMY = 4;    // dummy edges for 3B

    localparam logic [23:0] JEDEC_ID = 24'hC2_2017;  // manufacturer, type, capacity

    // offset bits inside a page
    localparam logic [ADDR_BITS-1:0] PAGE_MASK = ADDR_BITS'(PAGE_BYTES - 1);

    typedef enum logic [7:0] {
        CMD_RDID      = 8'h9F,
        CMD_RDSR      = 8'h05,
        CMD_WREN      = 8'h06,
        CMD_WRDI      = 8'h04,
        CMD_READ      = 8'h03,
        CMD_FAST_READ = 8'h0B,
        CMD_DUAL_READ = 8'h3B,  // 1-1-2
        CMD_PP        = 8'h02,
        CMD_QPP       = 8'h32,  // 1-1-4
        CMD_SE        = 8'h20
    } opcode_e;

    typedef enum logic [2:0] {
        ST_CMD,
        ST_ADDR,
        ST_DUMMY,
        ST_READ,
        ST_PROGRAM,
        ST_ID,
        ST_STATUS,
        ST_DONE     // wait here until cs_n rises
    } fsm_state_e;

    typedef enum logic [1:0] {
        LANE_X1,
        LANE_X2,
        LANE_X4
    } lane_mode_e;

    // single byte write into the array
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           data;
    } mem_write_t;

    typedef struct packed {
        logic wip;
        logic wel;
    } status_t;

    // one-cycle pulses from the command FSM
    typedef struct packed {
        logic                 byte_written;
        logic                 erase_start;
        logic [ADDR_BITS-1:0] erase_addr;
    } prog_req_t;

endpackage

`default_nettype wire

//--- protocol/qspi_lane_shifter.sv
// x1/x2/x4 byte shifter: serial-in and serial-out registers, bit counter and byte-done strobe
`default_nettype none

module qspi_lane_shifter (
    input  logic                       qspi_sclk,
    input  logic                       qspi_cs_n,
    input  qspi_flash_pkg::lane_mode_e lanes,
    input  logic                       clear,
    input  logic                       load,
    input  logic [7:0]                 load_byte,
    input  logic [3:0]                 pad_in,
    output logic [3:0]                 pad_out,
    output logic [7:0]                 in_byte,
    output logic                       byte_done
);
    import qspi_flash_pkg::*;

    logic [7:0] in_sr;
    logic [7:0] out_sr;
    logic [2:0] bit_cnt;
    logic [2:0] next_cnt;
    logic [2:0] step;       // bits per edge

    always_comb begin
        case (lanes)
            LANE_X2: begin
                step    = 3'd2;
                in_byte = {in_sr[5:0], pad_in[1:0]};
                pad_out = {2'b00, out_sr[7:6]};  // IO1 carries the higher bit
            end
            LANE_X4: begin
                step    = 3'd4;
                in_byte = {in_sr[3:0], pad_in};
                pad_out = out_sr[7:4];
            end
            default: begin
                step    = 3'd1;
                in_byte = {in_sr[6:0], pad_in[0]};  // SI on IO0
                pad_out = {2'b00, out_sr[7], 1'b0}; // SO on IO1
            end
        endcase
    end

    // counter wraps to zero on the edge that completes a byte
    assign next_cnt  = bit_cnt + step;
    assign byte_done = (next_cnt == 3'd0);

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            bit_cnt <= 3'd0;
            in_sr   <= 8'h00;
            out_sr  <= 8'h00;
        end else begin
            in_sr   <= in_byte;
            bit_cnt <= (clear || load) ? 3'd0 : next_cnt;
            if (load) begin
                out_sr <= load_byte;  // no gap between streamed bytes
            end else begin
                out_sr <= out_sr << step;
            end
        end
    end

    // lane width may only change on a byte boundary
    a_lanes_stable: assert property (@(posedge qspi_sclk) disable iff (qspi_cs_n)
        (bit_cnt != 3'd0) |-> $stable(lanes))
        else $error("lane mode changed in the middle of a byte");

endmodule

`default_nettype wire

//--- protocol/qspi_cmd_fsm.sv
// command FSM: opcode decode, address capture, dummy count, read/program/ID/status phases
`default_nettype none

module qspi_cmd_fsm (
    input  logic                                    qspi_sclk,
    input  logic                                    qspi_cs_n,
    input  logic [7:0]                              in_byte,
    input  logic                                    byte_done,
    output qspi_flash_pkg::lane_mode_e              lanes,
    output logic                                    load,
    output logic [7:0]                              out_byte,
    output logic                                    clear,
    output logic [3:0]                              oe,
    output logic [qspi_flash_pkg::ADDR_BITS-1:0]    rd_addr,
    input  logic [7:0]                              rd_data,
    output qspi_flash_pkg::mem_write_t              wr,
    input  qspi_flash_pkg::status_t                 status,
    output qspi_flash_pkg::prog_req_t               prog,
    output logic                                    set_wel,
    output logic                                    clr_wel
);
    import qspi_flash_pkg::*;

    fsm_state_e           state, state_d;
    opcode_e              cmd, cmd_d;
    logic [ADDR_BITS-1:0] addr, addr_d;      // next byte to send or program
    logic [1:0]           addr_cnt, addr_cnt_d;
    logic [3:0]           dummy_cnt, dummy_d;
    logic [1:0]           id_idx, id_d;      // next JEDEC byte
    logic [ADDR_BITS-1:0] addr_new;
    logic                 last_addr;
    logic                 wr_ok;
    logic [7:0]           status_byte;
    opcode_e              op;

    assign addr_new    = {addr[ADDR_BITS-9:0], in_byte};
    assign last_addr   = (addr_cnt == 2'(ADDR_BYTES - 1));
    assign wr_ok       = status.wel && !status.wip;  // program and erase gate
    assign status_byte = {6'b000000, status.wel, status.wip};
    assign op          = opcode_e'(in_byte);

    // memory is read at the address being completed during the address phase
    assign rd_addr = (state == ST_ADDR) ? addr_new : addr;

    always_comb begin
        state_d    = state;
        cmd_d      = cmd;
        addr_d     = addr;
        addr_cnt_d = addr_cnt;
        dummy_d    = dummy_cnt;
        id_d       = id_idx;
        load       = 1'b0;
        out_byte   = rd_data;
        clear      = 1'b0;
        set_wel    = 1'b0;
        clr_wel    = 1'b0;
        prog       = '0;
        wr         = '0;
        case (state)
            ST_CMD: begin
                if (byte_done) begin
                    cmd_d      = op;
                    addr_cnt_d = 2'd0;
                    case (op)
                        CMD_RDID: begin
                            load     = 1'b1;
                            out_byte = JEDEC_ID[23:16];
                            id_d     = 2'd1;
                            state_d  = ST_ID;
                        end
                        CMD_RDSR: begin
                            load     = 1'b1;
                            out_byte = status_byte;
                            state_d  = ST_STATUS;
                        end
                        CMD_WREN: begin
                            set_wel = 1'b1;
                            state_d = ST_DONE;
                        end
                        CMD_WRDI: begin
                            clr_wel = 1'b1;
                            state_d = ST_DONE;
                        end
                        CMD_READ, CMD_FAST_READ, CMD_DUAL_READ: state_d = ST_ADDR;
                        CMD_PP, CMD_QPP, CMD_SE: state_d = wr_ok ? ST_ADDR : ST_DONE;
                        default: state_d = ST_DONE;  // unknown opcode
                    endcase
                end
            end
            ST_ADDR: begin
                if (byte_done) begin
                    addr_d     = addr_new;
                    addr_cnt_d = addr_cnt + 2'd1;
                    if (last_addr) begin
                        case (cmd)
                            CMD_READ: begin
                                load    = 1'b1;  // first byte goes out right away
                                addr_d  = addr_new + 1'b1;
                                state_d = ST_READ;
                            end
                            CMD_FAST_READ: begin
                                dummy_d = 4'(FAST_DUMMY - 1);
                                state_d = ST_DUMMY;
                            end
                            CMD_DUAL_READ: begin
                                dummy_d = 4'(DUAL_DUMMY - 1);
                                state_d = ST_DUMMY;
                            end
                            CMD_SE: begin
                                prog.erase_start = 1'b1;
                                prog.erase_addr  = addr_new;
                                state_d          = ST_DONE;
                            end
                            default: state_d = ST_PROGRAM;  // PP and QPP
                        endcase
                    end
                end
            end
            ST_DUMMY: begin
                clear = 1'b1;  // hold the bit counter during dummy edges
                if (dummy_cnt == 4'd0) begin
                    load    = 1'b1;
                    addr_d  = addr + 1'b1;
                    state_d = ST_READ;
                end else begin
                    dummy_d = dummy_cnt - 4'd1;
                end
            end
            ST_READ: begin
                if (byte_done) begin
                    load   = 1'b1;  // stream continues until cs_n rises
                    addr_d = addr + 1'b1;
                end
            end
            ST_PROGRAM: begin
                if (byte_done) begin
                    wr.valid          = 1'b1;
                    wr.addr           = addr;
                    wr.data           = in_byte;
                    prog.byte_written = 1'b1;
                    addr_d = (addr & ~PAGE_MASK) | ((addr + 1'b1) & PAGE_MASK);  // page wrap
                end
            end
            ST_ID: begin
                if (byte_done) begin
                    case (id_idx)
                        2'd1: begin
                            load     = 1'b1;
                            out_byte = JEDEC_ID[15:8];
                            id_d     = 2'd2;
                        end
                        2'd2: begin
                            load     = 1'b1;
                            out_byte = JEDEC_ID[7:0];
                            id_d     = 2'd3;
                        end
                        default: state_d = ST_DONE;  // 24 bits sent
                    endcase
                end
            end
            ST_STATUS: begin
                if (byte_done) begin
                    load     = 1'b1;
                    out_byte = status_byte;  // live value each repeat
                end
            end
            ST_DONE: clear = 1'b1;
            default: state_d = ST_DONE;
        endcase
    end

    // lane mode and pad enables per phase
    always_comb begin
        lanes = LANE_X1;
        oe    = 4'b0000;
        case (state)
            ST_ID, ST_STATUS: oe = 4'b0010;
            ST_READ: begin
                if (cmd == CMD_DUAL_READ) begin
                    lanes = LANE_X2;
                    oe    = 4'b0011;
                end else begin
                    oe = 4'b0010;
                end
            end
            ST_PROGRAM: if (cmd == CMD_QPP) lanes = LANE_X4;
            default: ;
        endcase
    end

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            state     <= ST_CMD;
            addr_cnt  <= 2'd0;
            dummy_cnt <= 4'd0;
            id_idx    <= 2'd0;
        end else begin
            state     <= state_d;
            addr_cnt  <= addr_cnt_d;
            dummy_cnt <= dummy_d;
            id_idx    <= id_d;
        end
    end

    always_ff @(posedge qspi_sclk) begin
        cmd  <= cmd_d;
        addr <= addr_d;
    end

    // pads are driven only in output phases
    a_oe_phase: assert property (@(posedge qspi_sclk) disable iff (qspi_cs_n)
        (oe != 4'b0000) |-> (state inside {ST_ID, ST_STATUS, ST_READ}))
        else $error("pad output enabled in state %s", state.name());

endmodule

`default_nettype wire

//--- array/flash_array.sv
// flash byte array: combinational read port, synchronous write port, erased at power-up
`default_nettype none

module flash_array #(
    parameter int MEM_BYTES = 16384
) (
    input  logic                                 qspi_sclk,
    input  logic [qspi_flash_pkg::ADDR_BITS-1:0] rd_addr,
    output logic [7:0]                           rd_data,
    input  qspi_flash_pkg::mem_write_t           wr
);
    import qspi_flash_pkg::*;

    localparam int IDX_BITS = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];

    // erased flash reads all ones
    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'hFF;
        end
    end

    assign rd_data = mem[rd_addr[IDX_BITS-1:0]];  // upper address bits alias

    always_ff @(posedge qspi_sclk) begin
        if (wr.valid) begin
            mem[wr.addr[IDX_BITS-1:0]] <= wr.data;
        end
    end

endmodule

`default_nettype wire

//--- source/flash_busy_ctrl.sv
// status control: WEL and WIP bits, program busy countdown and sector erase walker
`default_nettype none

module flash_busy_ctrl #(
    parameter int SECTOR_BYTES   = 4096,
    parameter int PROGRAM_CYCLES = 32
) (
    input  logic                       qspi_sclk,
    input  qspi_flash_pkg::prog_req_t  prog,
    input  logic                       set_wel,
    input  logic                       clr_wel,
    output qspi_flash_pkg::status_t    status,
    output qspi_flash_pkg::mem_write_t erase_wr
);
    import qspi_flash_pkg::*;

    localparam int PCNT_BITS = $clog2(PROGRAM_CYCLES + 1);
    localparam int ECNT_BITS = $clog2(SECTOR_BYTES + 1);
    localparam logic [ADDR_BITS-1:0] SECTOR_MASK = ADDR_BITS'(SECTOR_BYTES - 1);

    // keeps running across chip selects, starts idle at power-up
    logic                 wip        = 1'b0;
    logic                 wel        = 1'b0;
    logic [PCNT_BITS-1:0] prog_cnt   = '0;
    logic [ECNT_BITS-1:0] erase_left = '0;   // bytes still to erase
    logic [ADDR_BITS-1:0] erase_ptr  = '0;
    logic                 busy_end;

    // last edge of either countdown, unless new work arrives
    assign busy_end = !prog.byte_written && !prog.erase_start &&
                      ((prog_cnt == PCNT_BITS'(1)) || (erase_left == ECNT_BITS'(1)));

    always_ff @(posedge qspi_sclk) begin
        if (prog.byte_written) begin
            prog_cnt <= PCNT_BITS'(PROGRAM_CYCLES);  // each byte restarts the timer
        end else if (prog_cnt != '0) begin
            prog_cnt <= prog_cnt - 1'b1;
        end

        if (prog.erase_start) begin
            erase_left <= ECNT_BITS'(SECTOR_BYTES);
            erase_ptr  <= prog.erase_addr & ~SECTOR_MASK;  // align to sector start
        end else if (erase_left != '0) begin
            erase_left <= erase_left - 1'b1;
            erase_ptr  <= erase_ptr + 1'b1;
        end

        if (prog.byte_written || prog.erase_start) begin
            wip <= 1'b1;
        end else if (busy_end) begin
            wip <= 1'b0;
        end

        if (busy_end) begin
            wel <= 1'b0;
        end else if (set_wel) begin
            wel <= 1'b1;
        end else if (clr_wel) begin
            wel <= 1'b0;
        end
    end

    assign status.wip     = wip;
    assign status.wel     = wel;
    assign erase_wr.valid = (erase_left != '0);
    assign erase_wr.addr  = erase_ptr;
    assign erase_wr.data  = 8'hFF;

    a_one_request: assert property (@(posedge qspi_sclk)
        !(prog.byte_written && prog.erase_start))
        else $error("program and erase requested together");

    a_erase_busy: assert property (@(posedge qspi_sclk) erase_wr.valid |-> status.wip)
        else $error("erase write while WIP is clear");

endmodule

`default_nettype wire

//--- source/qspi_flash_top.sv
// flash model top level: pad tristates, array write-port select and block instances
`default_nettype none

module qspi_flash_top #(
    parameter int MEM_BYTES      = 16384,
    parameter int SECTOR_BYTES   = 4096,
    parameter int PROGRAM_CYCLES = 32
) (
    input  logic qspi_sclk,
    input  logic qspi_cs_n,
    inout  wire  io0,
    inout  wire  io1,
    inout  wire  io2,
    inout  wire  io3
);
    import qspi_flash_pkg::*;

    lane_mode_e           lanes;
    logic                 load;
    logic                 clear;
    logic                 byte_done;
    logic [7:0]           out_byte;
    logic [7:0]           in_byte;
    logic [3:0]           oe;
    logic [3:0]           pad_in;
    logic [3:0]           pad_out;
    logic [ADDR_BITS-1:0] rd_addr;
    logic [7:0]           rd_data;
    mem_write_t           fsm_wr;
    mem_write_t           erase_wr;
    mem_write_t           arr_wr;
    status_t              status;
    prog_req_t            prog;
    logic                 set_wel;
    logic                 clr_wel;

    assign pad_in = {io3, io2, io1, io0};

    assign io0 = oe[0] ? pad_out[0] : 1'bz;
    assign io1 = oe[1] ? pad_out[1] : 1'bz;  // SO in x1 mode
    assign io2 = oe[2] ? pad_out[2] : 1'bz;
    assign io3 = oe[3] ? pad_out[3] : 1'bz;

    // the erase walker wins, it only runs while no command may write
    assign arr_wr = erase_wr.valid ? erase_wr : fsm_wr;

    qspi_cmd_fsm u_fsm (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .in_byte   (in_byte),
        .byte_done (byte_done),
        .lanes     (lanes),
        .load      (load),
        .out_byte  (out_byte),
        .clear     (clear),
        .oe        (oe),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .wr        (fsm_wr),
        .status    (status),
        .prog      (prog),
        .set_wel   (set_wel),
        .clr_wel   (clr_wel)
    );

    qspi_lane_shifter u_shifter (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .lanes     (lanes),
        .clear     (clear),
        .load      (load),
        .load_byte (out_byte),
        .pad_in    (pad_in),
        .pad_out   (pad_out),
        .in_byte   (in_byte),
        .byte_done (byte_done)
    );

    flash_array #(
        .MEM_BYTES (MEM_BYTES)
    ) u_array (
        .qspi_sclk (qspi_sclk),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .wr        (arr_wr)
    );

    flash_busy_ctrl #(
        .SECTOR_BYTES   (SECTOR_BYTES),
        .PROGRAM_CYCLES (PROGRAM_CYCLES)
    ) u_busy (
        .qspi_sclk (qspi_sclk),
        .prog      (prog),
        .set_wel   (set_wel),
        .clr_wel   (clr_wel),
        .status    (status),
        .erase_wr  (erase_wr)
    );

endmodule

`default_nettype wire

//--- test/qspi_host_tasks.svh
// host tasks for QSPI command framing, address and data output, x1 and x2 data input
`ifndef QSPI_HOST_TASKS_SVH
`define QSPI_HOST_TASKS_SVH

// every task is entered and left right after a falling edge of sclk

task automatic send_x1(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
        io_val[0] = b[i];  // SI on IO0
        @(negedge sclk);
    end
endtask

task automatic send_x4(input logic [7:0] b);
    io_val = b[7:4];  // IO3 takes the highest bit
    @(negedge sclk);
    io_val = b[3:0];
    @(negedge sclk);
endtask

task automatic recv_x1(output logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
        b[i] = io1;
        @(negedge sclk);
    end
endtask

task automatic recv_x2(output logic [7:0] b);
    for (int i = 3; i >= 0; i--) begin
        b[2*i+1] = io1;  // higher bit of the pair
        b[2*i]   = io0;
        @(negedge sclk);
    end
endtask

task automatic skip_edges(input int n);
    repeat (n) @(negedge sclk);
endtask

// chip select falls together with the first opcode bit
task automatic begin_cmd(input logic [7:0] op);
    cs_n  = 1'b0;
    io_oe = 4'b0001;
    send_x1(op);
endtask

task automatic send_addr(input logic [23:0] addr);
    send_x1(addr[23:16]);
    send_x1(addr[15:8]);
    send_x1(addr[7:0]);
endtask

// deselect, the clock keeps running for the busy timers
task automatic end_cmd();
    cs_n   = 1'b1;
    io_oe  = 4'b0001;
    io_val = 4'b0000;
    skip_edges(4);
endtask

task automatic opcode_only(input logic [7:0] op);
    begin_cmd(op);
    end_cmd();
endtask

task automatic get_status(output logic [7:0] s);
    begin_cmd(CMD_RDSR);
    recv_x1(s);
    end_cmd();
endtask

`endif

//--- test/tb_qspi_flash.sv
// testbench for the QSPI flash model with clock, host stimulus, reference memory and checks
`default_nettype none

module tb_qspi_flash;
    import qspi_flash_pkg::*;

    localparam int MEM_BYTES      = 16384;
    localparam int SECTOR_BYTES   = 4096;
    localparam int PROGRAM_CYCLES = 32;
    localparam int POLL_LIMIT     = 1000;  // erase needs about 200 polls

    logic       sclk;
    logic       cs_n;
    logic [3:0] io_oe;
    logic [3:0] io_val;
    wire        io0;
    wire        io1;
    wire        io2;
    wire        io3;
    logic [7:0] model [MEM_BYTES];  // expected array contents
    logic [7:0] pat [32];           // data of the next program command

    assign io0 = io_oe[0] ? io_val[0] : 1'bz;
    assign io1 = io_oe[1] ? io_val[1] : 1'bz;
    assign io2 = io_oe[2] ? io_val[2] : 1'bz;
    assign io3 = io_oe[3] ? io_val[3] : 1'bz;

    qspi_flash_top #(
        .MEM_BYTES      (MEM_BYTES),
        .SECTOR_BYTES   (SECTOR_BYTES),
        .PROGRAM_CYCLES (PROGRAM_CYCLES)
    ) dut0 (
        .qspi_sclk (sclk),
        .qspi_cs_n (cs_n),
        .io0       (io0),
        .io1       (io1),
        .io2       (io2),
        .io3       (io3)
    );

    `include "qspi_host_tasks.svh"

    initial begin
        sclk = 1'b0;
        forever #4 sclk = ~sclk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp)
            else abort_run($sformatf("** Error @ %0t: %s got %02h, expected %02h",
                                     $time, what, got, exp));
    endtask

    // RDSR repeats the status byte, so two are checked
    task automatic check_status(input logic [7:0] exp);
        logic [7:0] s;
        begin_cmd(CMD_RDSR);
        for (int i = 0; i < 2; i++) begin
            recv_x1(s);
            check_byte(s, exp, "status byte");
        end
        end_cmd();
    endtask

    task automatic wait_wip_clear();
        logic [7:0] s;
        int         polls;
        polls = 0;
        s     = 8'h01;
        while (s[0]) begin
            if (polls == POLL_LIMIT) begin
                abort_run($sformatf("timeout, WIP still set after %0d status polls", polls));
            end else begin
                get_status(s);
                polls++;
            end
        end
    endtask

    task automatic fill_pattern(input int n);
        for (int i = 0; i < n; i++) begin
            pat[i] = 8'($urandom);
        end
    endtask

    // apply tells whether the flash must accept the data
    task automatic program_bytes(input logic [7:0] op, input logic [23:0] addr, input int n,
                                 input bit apply);
        logic [23:0] a;
        begin_cmd(op);
        send_addr(addr);
        if (op == CMD_QPP) begin
            io_oe = 4'b1111;
        end
        a = addr;
        for (int i = 0; i < n; i++) begin
            if (op == CMD_QPP) begin
                send_x4(pat[i]);
            end else begin
                send_x1(pat[i]);
            end
            if (apply) begin
                model[int'(a) % MEM_BYTES] = pat[i];
            end
            a = {a[23:8], a[7:0] + 8'd1};  // stays inside the 256-byte page
        end
        end_cmd();
    endtask

    task automatic erase_model(input logic [23:0] addr);
        int base;
        base = (int'(addr) / SECTOR_BYTES) * SECTOR_BYTES;
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            model[(base + i) % MEM_BYTES] = 8'hFF;
        end
    endtask

    task automatic read_check(input logic [7:0] op, input logic [23:0] addr, input int n);
        logic [7:0] got;
        int         idx;
        begin_cmd(op);
        send_addr(addr);
        if (op == CMD_FAST_READ) begin
            skip_edges(8);
        end
        if (op == CMD_DUAL_READ) begin
            io_oe = 4'b0000;  // flash drives IO0 after the dummy edges
            skip_edges(4);
        end
        for (int i = 0; i < n; i++) begin
            if (op == CMD_DUAL_READ) begin
                recv_x2(got);
            end else begin
                recv_x1(got);
            end
            idx = (int'(addr) + i) % MEM_BYTES;
            check_byte(got, model[idx], $sformatf("read %02h at %06h", op, int'(addr) + i));
        end
        end_cmd();
    endtask

    initial begin
        logic [7:0] b;
        cs_n   = 1'b1;
        io_oe  = 4'b0001;
        io_val = 4'b0000;
        void'($urandom(32'hb5a3_71d6));
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'hFF;
        end
        skip_edges(4);

        // ID bytes and status after reset
        begin_cmd(CMD_RDID);
        recv_x1(b);
        check_byte(b, 8'hC2, "RDID byte 0");
        recv_x1(b);
        check_byte(b, 8'h20, "RDID byte 1");
        recv_x1(b);
        check_byte(b, 8'h17, "RDID byte 2");
        end_cmd();
        check_status(8'h00);

        // write enable latch, then a program that must be ignored
        opcode_only(CMD_WREN);
        check_status(8'h02);
        opcode_only(CMD_WRDI);
        check_status(8'h00);
        fill_pattern(8);
        program_bytes(CMD_PP, 24'h002100, 8, 1'b0);
        check_status(8'h00);
        read_check(CMD_READ, 24'h002100, 8);

        // page program across the page end wraps to the page start
        opcode_only(CMD_WREN);
        fill_pattern(32);
        program_bytes(CMD_PP, 24'h0001F0, 32, 1'b1);
        wait_wip_clear();
        check_status(8'h00);
        read_check(CMD_READ, 24'h0001F0, 24);  // runs into the next page
        read_check(CMD_FAST_READ, 24'h000100, 24);

        // quad program, dual read back
        opcode_only(CMD_WREN);
        fill_pattern(16);
        program_bytes(CMD_QPP, 24'h000300, 16, 1'b1);
        wait_wip_clear();
        read_check(CMD_DUAL_READ, 24'h000300, 16);

        // sector 1 gets data at both ends, then is erased
        opcode_only(CMD_WREN);
        fill_pattern(8);
        program_bytes(CMD_PP, 24'h001FF8, 8, 1'b1);
        wait_wip_clear();
        opcode_only(CMD_WREN);
        fill_pattern(8);
        program_bytes(CMD_PP, 24'h001000, 8, 1'b1);
        wait_wip_clear();
        read_check(CMD_READ, 24'h001FF0, 16);
        read_check(CMD_READ, 24'h001000, 8);
        opcode_only(CMD_WREN);
        begin_cmd(CMD_SE);
        send_addr(24'h001234);
        end_cmd();
        erase_model(24'h001234);
        check_status(8'h03);
        fill_pattern(8);
        program_bytes(CMD_PP, 24'h0001F0, 8, 1'b0);  // rejected while busy
        wait_wip_clear();
        check_status(8'h00);
        read_check(CMD_READ, 24'h001000, 8);
        read_check(CMD_READ, 24'h001800, 8);
        read_check(CMD_READ, 24'h001FF8, 8);
        read_check(CMD_READ, 24'h000FF8, 16);
        read_check(CMD_READ, 24'h0001F0, 16);
        read_check(CMD_READ, 24'h000300, 16);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+test
common/qspi_flash_pkg.sv
protocol/qspi_lane_shifter.sv
protocol/qspi_cmd_fsm.sv
array/flash_array.sv
source/flash_busy_ctrl.sv
source/qspi_flash_top.sv
test/tb_qspi_flash.sv

//--- Bender.yml
package:
  name: qspi_flash

sources:
  - files:
      - common/qspi_flash_pkg.sv
      - protocol/qspi_lane_shifter.sv
      - protocol/qspi_cmd_fsm.sv
      - array/flash_array.sv
      - source/flash_busy_ctrl.sv
      - source/qspi_flash_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_qspi_flash.sv
